// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := monu_tb
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The run passes only when the log holds the pass line
run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^Everything OK$$" $(LOG) || (echo "Simulation did not pass" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim.f ====
+incdir+source
source/monu_pkg.sv
source/monu_wr_if.sv
source/monu_axi_wr.sv
source/monu_axi_rd.sv
source/monu_status_sampler.sv
source/monu_reg_file.sv
source/monu_top.sv
tb/monu_clk_gen.sv
tb/monu_props.sv
tb/monu_tb.sv

// ==== source/monu_axi_rd.sv ====
`include "monu_defines.svh"

module monu_axi_rd
  import monu_pkg::*;
(
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  // Read address
  input  logic [`MONU_ADDR_W-1:0] i_araddr,
  input  logic                    i_arvalid,
  output logic                    o_arready,
  // Read data
  output word_t                   o_rdata,
  output logic [1:0]              o_rresp,
  output logic                    o_rvalid,
  input  logic                    i_rready,
  // Register read port
  output logic                    o_rd_en,
  output reg_idx_t                o_rd_idx,
  input  word_t                   i_rd_data
);

  logic     arready_q;
  logic     rvalid_q;
  logic     ar_take;
  logic     rd_fire;
  reg_idx_t ar_idx;
  word_t    rdata_q;

  // No new address while read data is still pending
  assign ar_take = !arready_q && i_arvalid && !rvalid_q;
  assign rd_fire = arready_q && i_arvalid;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      arready_q <= 1'b0;
    end else begin
      arready_q <= ar_take;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (ar_take) begin
      ar_idx <= i_araddr[`MONU_ADDR_LSB +: `MONU_IDX_W];
    end
  end

  // --------------------
  // Read data, stable until RREADY
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
      rdata_q  <= i_rd_data;
    end else if (rvalid_q && i_rready) begin
      rvalid_q <= 1'b0;
    end
  end

  assign o_arready = arready_q;
  assign o_rvalid  = rvalid_q;
  assign o_rdata   = rdata_q;
  assign o_rresp   = `MONU_RESP_OKAY;
  assign o_rd_en   = rd_fire;
  assign o_rd_idx  = ar_idx;

endmodule

// ==== source/monu_axi_wr.sv ====
`include "monu_defines.svh"

module monu_axi_wr
  import monu_pkg::*;
(
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  // Write address
  input  logic [`MONU_ADDR_W-1:0] i_awaddr,
  input  logic                    i_awvalid,
  output logic                    o_awready,
  // Write data
  input  word_t                   i_wdata,
  input  strb_t                   i_wstrb,
  input  logic                    i_wvalid,
  output logic                    o_wready,
  // Write response
  output logic [1:0]              o_bresp,
  output logic                    o_bvalid,
  input  logic                    i_bready,
  // Register write port
  monu_wr_if.src                  wr
);

  logic     aw_en;
  logic     ready_q;
  logic     bvalid_q;
  logic     aw_take;
  logic     wr_fire;
  reg_idx_t aw_idx;

  // Address and data must both be present, one write in flight at a time
  assign aw_take = !ready_q && i_awvalid && i_wvalid && aw_en;
  assign wr_fire = ready_q && i_awvalid && i_wvalid;

  // --------------------
  // Ready pulse and outstanding-write flag
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      ready_q <= 1'b0;
      aw_en   <= 1'b1;
    end else if (aw_take) begin
      ready_q <= 1'b1;
      aw_en   <= 1'b0;
    end else begin
      ready_q <= 1'b0;
      // Reopen only once the response has been taken
      if (bvalid_q && i_bready) begin
        aw_en <= 1'b1;
      end
    end
  end

  // Word index of the accepted address
  always_ff @(posedge S_AXI_ACLK) begin
    if (aw_take) begin
      aw_idx <= i_awaddr[`MONU_ADDR_LSB +: `MONU_IDX_W];
    end
  end

  // --------------------
  // Response, held until the master takes it
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      bvalid_q <= 1'b0;
    end else if (wr_fire) begin
      bvalid_q <= 1'b1;
    end else if (bvalid_q && i_bready) begin
      bvalid_q <= 1'b0;
    end
  end

  assign o_awready = ready_q;
  assign o_wready  = ready_q;
  assign o_bvalid  = bvalid_q;
  assign o_bresp   = `MONU_RESP_OKAY;

  assign wr.wr_en   = wr_fire;
  assign wr.wr_idx  = aw_idx;
  assign wr.wr_data = i_wdata;
  assign wr.wr_strb = i_wstrb;

endmodule

// ==== source/monu_defines.svh ====
`ifndef MONU_DEFINES_SVH
`define MONU_DEFINES_SVH

// --------------------
// Bus widths
`define MONU_DATA_W       32
`define MONU_ADDR_W       32
`define MONU_ADDR_LSB     2
`define MONU_IDX_W        8
`define MONU_RESP_OKAY    2'b00

// --------------------
// Status bank, word indices 0x00 to 0x11
`define MONU_DP_N         8
`define MONU_STAT_N       18
`define MONU_STAT_RSVD    6
`define MONU_STAT_FLAG    7
`define MONU_STAT_DP_BASE 10

// --------------------
// Control bank, offsets from the base index
`define MONU_CTRL_BASE    8'h18
`define MONU_CTRL_N       14
`define MONU_USER_N       4

`define MONU_CTRL_CU_PARAM    0
`define MONU_CTRL_MEMMU_PARAM 1
`define MONU_CTRL_EXMU_PARAM  2
`define MONU_CTRL_MONU_PARAM  3
`define MONU_CTRL_SIU_PARAM   4
`define MONU_CTRL_PC_READY    5
`define MONU_CTRL_PROC_DONE   6
`define MONU_CTRL_PC_SIZE     7
`define MONU_CTRL_FRAME_DONE  8
`define MONU_CTRL_RSVD        9
`define MONU_CTRL_USER0       10

`endif

// ==== source/monu_pkg.sv ====
`include "monu_defines.svh"

package monu_pkg;

  // One register word on the AXI4-Lite data bus
  typedef logic [`MONU_DATA_W-1:0] word_t;

  // Word index, the byte address shifted down by the word size
  typedef logic [`MONU_IDX_W-1:0] reg_idx_t;

  // One strobe bit per data byte
  typedef logic [`MONU_DATA_W/8-1:0] strb_t;

  // Debug points, element 0 is debug point 0
  typedef logic [`MONU_DP_N-1:0][`MONU_DATA_W-1:0] dp_vec_t;

  // Status snapshot, element n sits at word index n
  typedef logic [`MONU_STAT_N-1:0][`MONU_DATA_W-1:0] stat_bank_t;

endpackage

// ==== source/monu_reg_file.sv ====
`include "monu_defines.svh"

module monu_reg_file
  import monu_pkg::*;
(
  input  logic                         S_AXI_ACLK,
  input  logic                         S_AXI_ARESETN,
  // Register write port
  monu_wr_if.dst                       wr,
  // Register read port
  input  reg_idx_t                     i_rd_idx,
  output word_t                        o_rd_data,
  // Status snapshot
  input  stat_bank_t                   i_stat,
  // Unit parameters
  output word_t                        o_cu_param,
  output word_t                        o_memmu_param,
  output word_t                        o_exmu_param,
  output word_t                        o_monu_param,
  output word_t                        o_siu_param,
  // Decoded flags
  output logic                         o_cu_pc_ready,
  output logic                         o_cu_processing_done,
  output logic                         o_cu_frame_done,
  output word_t                        o_point_cloud_size,
  output word_t [`MONU_USER_N-1:0]     o_user
);

  localparam int OFF_W  = $clog2(`MONU_CTRL_N);
  localparam int STAT_W = $clog2(`MONU_STAT_N);

  word_t [`MONU_CTRL_N-1:0] ctrl_q;
  reg_idx_t                 wr_off;
  reg_idx_t                 rd_off;
  logic                     wr_hit;

  // Below-base indices wrap to large offsets and miss the bank
  assign wr_off = wr.wr_idx - reg_idx_t'(`MONU_CTRL_BASE);
  assign rd_off = i_rd_idx - reg_idx_t'(`MONU_CTRL_BASE);
  assign wr_hit = wr.wr_en && (wr_off < reg_idx_t'(`MONU_CTRL_N));

  // --------------------
  // Control words, byte merge under the strobes
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      ctrl_q <= '0;
    end else if (wr_hit) begin
      for (int b = 0; b < `MONU_DATA_W / 8; b++) begin
        if (wr.wr_strb[b]) begin
          ctrl_q[wr_off[OFF_W-1:0]][b*8 +: 8] <= wr.wr_data[b*8 +: 8];
        end
      end
    end
  end

  // --------------------
  // Readback, status bank then control bank, zero elsewhere
  always_comb begin
    if (i_rd_idx < reg_idx_t'(`MONU_STAT_N)) begin
      o_rd_data = i_stat[i_rd_idx[STAT_W-1:0]];
    end else if (rd_off < reg_idx_t'(`MONU_CTRL_N)) begin
      o_rd_data = ctrl_q[rd_off[OFF_W-1:0]];
    end else begin
      o_rd_data = '0;
    end
  end

  assign o_cu_param    = ctrl_q[`MONU_CTRL_CU_PARAM];
  assign o_memmu_param = ctrl_q[`MONU_CTRL_MEMMU_PARAM];
  assign o_exmu_param  = ctrl_q[`MONU_CTRL_EXMU_PARAM];
  assign o_monu_param  = ctrl_q[`MONU_CTRL_MONU_PARAM];
  assign o_siu_param   = ctrl_q[`MONU_CTRL_SIU_PARAM];

  // Any nonzero word raises the flag
  assign o_cu_pc_ready        = |ctrl_q[`MONU_CTRL_PC_READY];
  assign o_cu_processing_done = |ctrl_q[`MONU_CTRL_PROC_DONE];
  assign o_cu_frame_done      = |ctrl_q[`MONU_CTRL_FRAME_DONE];

  assign o_point_cloud_size = ctrl_q[`MONU_CTRL_PC_SIZE];
  assign o_user             = ctrl_q[`MONU_CTRL_USER0 +: `MONU_USER_N];

endmodule

// ==== source/monu_status_sampler.sv ====
`include "monu_defines.svh"

module monu_status_sampler
  import monu_pkg::*;
(
  input  logic       S_AXI_ACLK,
  input  logic       S_AXI_ARESETN,
  // Unit status words
  input  word_t      i_cu_status,
  input  word_t      i_exmu_status,
  input  word_t      i_memmu_status,
  input  word_t      i_monu_status,
  input  word_t      i_siu_status,
  input  word_t      i_ext_status,
  // Handshake flags
  input  logic       i_cu_ext_ready,
  input  logic       i_cu_pc_ready,
  input  logic       i_cu_processing_done,
  // Debug points
  input  dp_vec_t    i_dp,
  output stat_bank_t o_stat,
  output logic       o_status
);

  // Snapshot follows the register map order
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      o_stat   <= '0;
      o_status <= 1'b0;
    end else begin
      o_stat[0] <= i_cu_status;
      o_stat[1] <= i_exmu_status;
      o_stat[2] <= i_memmu_status;
      o_stat[3] <= i_monu_status;
      o_stat[4] <= i_siu_status;
      o_stat[5] <= i_ext_status;
      o_stat[`MONU_STAT_RSVD] <= '0;
      // Flags read back zero-extended
      o_stat[`MONU_STAT_FLAG]     <= word_t'(i_cu_ext_ready);
      o_stat[`MONU_STAT_FLAG + 1] <= word_t'(i_cu_pc_ready);
      o_stat[`MONU_STAT_FLAG + 2] <= word_t'(i_cu_processing_done);
      for (int k = 0; k < `MONU_DP_N; k++) begin
        o_stat[`MONU_STAT_DP_BASE + k] <= i_dp[k];
      end
      // Alive once out of reset
      o_status <= 1'b1;
    end
  end

endmodule

// ==== source/monu_top.sv ====
`include "monu_defines.svh"

module monu_top
  import monu_pkg::*;
(
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  // AXI4-Lite write channels
  input  logic [`MONU_ADDR_W-1:0]  S_AXI_AWADDR,
  input  logic                     S_AXI_AWVALID,
  output logic                     S_AXI_AWREADY,
  input  word_t                    S_AXI_WDATA,
  input  strb_t                    S_AXI_WSTRB,
  input  logic                     S_AXI_WVALID,
  output logic                     S_AXI_WREADY,
  output logic [1:0]               S_AXI_BRESP,
  output logic                     S_AXI_BVALID,
  input  logic                     S_AXI_BREADY,
  // AXI4-Lite read channels
  input  logic [`MONU_ADDR_W-1:0]  S_AXI_ARADDR,
  input  logic                     S_AXI_ARVALID,
  output logic                     S_AXI_ARREADY,
  output word_t                    S_AXI_RDATA,
  output logic [1:0]               S_AXI_RRESP,
  output logic                     S_AXI_RVALID,
  input  logic                     S_AXI_RREADY,
  // Status inputs
  input  word_t                    i_cu_status,
  input  word_t                    i_exmu_status,
  input  word_t                    i_memmu_status,
  input  word_t                    i_monu_status,
  input  word_t                    i_siu_status,
  input  word_t                    i_ext_status,
  input  logic                     i_cu_ext_ready,
  input  logic                     i_cu_pc_ready,
  input  logic                     i_cu_processing_done,
  input  dp_vec_t                  i_dp,
  // Control outputs
  output word_t                    o_cu_param,
  output word_t                    o_memmu_param,
  output word_t                    o_exmu_param,
  output word_t                    o_monu_param,
  output word_t                    o_siu_param,
  output logic                     o_cu_pc_ready,
  output logic                     o_cu_processing_done,
  output logic                     o_cu_frame_done,
  output word_t                    o_point_cloud_size,
  output word_t [`MONU_USER_N-1:0] o_user,
  output logic                     o_status
);

  stat_bank_t stat;
  reg_idx_t   rd_idx;
  word_t      rd_data;

  monu_wr_if u_wr_if ();

  monu_axi_wr u_axi_wr (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .i_awaddr      (S_AXI_AWADDR),
    .i_awvalid     (S_AXI_AWVALID),
    .o_awready     (S_AXI_AWREADY),
    .i_wdata       (S_AXI_WDATA),
    .i_wstrb       (S_AXI_WSTRB),
    .i_wvalid      (S_AXI_WVALID),
    .o_wready      (S_AXI_WREADY),
    .o_bresp       (S_AXI_BRESP),
    .o_bvalid      (S_AXI_BVALID),
    .i_bready      (S_AXI_BREADY),
    .wr            (u_wr_if.src)
  );

  // Read data is registered inside the read channel block
  monu_axi_rd u_axi_rd (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .i_araddr      (S_AXI_ARADDR),
    .i_arvalid     (S_AXI_ARVALID),
    .o_arready     (S_AXI_ARREADY),
    .o_rdata       (S_AXI_RDATA),
    .o_rresp       (S_AXI_RRESP),
    .o_rvalid      (S_AXI_RVALID),
    .i_rready      (S_AXI_RREADY),
    .o_rd_en       (),
    .o_rd_idx      (rd_idx),
    .i_rd_data     (rd_data)
  );

  monu_status_sampler u_status_sampler (
    .S_AXI_ACLK           (S_AXI_ACLK),
    .S_AXI_ARESETN        (S_AXI_ARESETN),
    .i_cu_status          (i_cu_status),
    .i_exmu_status        (i_exmu_status),
    .i_memmu_status       (i_memmu_status),
    .i_monu_status        (i_monu_status),
    .i_siu_status         (i_siu_status),
    .i_ext_status         (i_ext_status),
    .i_cu_ext_ready       (i_cu_ext_ready),
    .i_cu_pc_ready        (i_cu_pc_ready),
    .i_cu_processing_done (i_cu_processing_done),
    .i_dp                 (i_dp),
    .o_stat               (stat),
    .o_status             (o_status)
  );

  monu_reg_file u_reg_file (
    .S_AXI_ACLK           (S_AXI_ACLK),
    .S_AXI_ARESETN        (S_AXI_ARESETN),
    .wr                   (u_wr_if.dst),
    .i_rd_idx             (rd_idx),
    .o_rd_data            (rd_data),
    .i_stat               (stat),
    .o_cu_param           (o_cu_param),
    .o_memmu_param        (o_memmu_param),
    .o_exmu_param         (o_exmu_param),
    .o_monu_param         (o_monu_param),
    .o_siu_param          (o_siu_param),
    .o_cu_pc_ready        (o_cu_pc_ready),
    .o_cu_processing_done (o_cu_processing_done),
    .o_cu_frame_done      (o_cu_frame_done),
    .o_point_cloud_size   (o_point_cloud_size),
    .o_user               (o_user)
  );

endmodule

// ==== source/monu_wr_if.sv ====
// Register write port between the AXI write channels and the register file
interface monu_wr_if;

  // Single-cycle pulse, no back-pressure
  logic               wr_en;
  monu_pkg::reg_idx_t wr_idx;
  monu_pkg::word_t    wr_data;
  monu_pkg::strb_t    wr_strb;

  modport src (
    output wr_en,
    output wr_idx,
    output wr_data,
    output wr_strb
  );

  modport dst (
    input wr_en,
    input wr_idx,
    input wr_data,
    input wr_strb
  );

endinterface

// ==== tb/monu_clk_gen.sv ====
module monu_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  // 8 ns period
  initial begin
    o_clk = 1'b0;
    forever #4 o_clk = ~o_clk;
  end

  // Reset held low over the first 5 rising edges
  initial begin
    o_rst_n = 1'b0;
    repeat (5) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

// ==== tb/monu_props.sv ====
module monu_props
  import monu_pkg::*;
(
  input logic  i_clk,
  input logic  i_rst_n,
  input logic  i_awvalid,
  input logic  i_wvalid,
  input logic  i_awready,
  input logic  i_wready,
  input logic  i_bvalid,
  input logic  i_bready,
  input logic  i_arready,
  input logic  i_rvalid,
  input logic  i_rready,
  input word_t i_rdata
);

  timeunit 1ns;
  timeprecision 100ps;

  // --------------------
  // Write channels
  a_bvalid_hold : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_bvalid && !i_bready |=> i_bvalid)
    else $error("BVALID dropped before BREADY was seen");

  // Both readies rise only once address and data were both offered
  a_ready_pair : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(i_awready) |-> i_wready && $past(i_awvalid && i_wvalid))
    else $error("AWREADY and WREADY did not rise together after both valids");

  // --------------------
  // Read channels
  a_rdata_hold : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata))
    else $error("RVALID or RDATA changed before RREADY was seen");

  a_no_ar_while_r : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_arready && i_rvalid))
    else $error("ARREADY high while read data is pending");

endmodule

// ==== tb/monu_tb.sv ====
`include "monu_defines.svh"

module monu_tb
  import monu_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CTRL_BASE = int'(`MONU_CTRL_BASE);
  // About 100 transfers, none longer than 30 cycles
  localparam int MAX_CYCLES = 100 * 30;
  // Status, gap and out-of-map indices
  localparam reg_idx_t NO_WRITE_IDX [5] = '{8'h02, 8'h12, 8'h17, 8'h26, 8'hFF};

  logic                     S_AXI_ACLK;
  logic                     S_AXI_ARESETN;
  logic [`MONU_ADDR_W-1:0]  S_AXI_AWADDR;
  logic [`MONU_ADDR_W-1:0]  S_AXI_ARADDR;
  logic                     S_AXI_AWVALID, S_AXI_AWREADY, S_AXI_WVALID, S_AXI_WREADY;
  logic                     S_AXI_BVALID, S_AXI_BREADY, S_AXI_ARVALID, S_AXI_ARREADY;
  logic                     S_AXI_RVALID, S_AXI_RREADY;
  logic [1:0]               S_AXI_BRESP, S_AXI_RRESP;
  word_t                    S_AXI_WDATA, S_AXI_RDATA;
  strb_t                    S_AXI_WSTRB;
  // Status sources in map order
  word_t                    stat_in [6];
  logic [2:0]               flag_in;
  dp_vec_t                  dp_in;
  word_t                    cu_param, memmu_param, exmu_param, monu_param, siu_param;
  logic                     pc_ready, proc_done, frame_done, alive;
  word_t                    pc_size;
  word_t [`MONU_USER_N-1:0] user_out;

  word_t    ctrl_model [`MONU_CTRL_N];
  integer   seed;
  reg_idx_t rd_idx_last;
  word_t    rd_got_last;
  // Set once a reset edge has cleared the control registers
  logic     regs_cleared = 1'b0;
  int       rd_count = 0;
  int       rd_seen = 0;
  int       checks = 0;
  int       err_value = 0;
  int       err_bus = 0;
  int       err_proto = 0;
  int       cycles = 0;

  monu_clk_gen u_clk_gen (
    .o_clk   (S_AXI_ACLK),
    .o_rst_n (S_AXI_ARESETN)
  );

  monu_top u_dut (
    .S_AXI_ACLK           (S_AXI_ACLK),
    .S_AXI_ARESETN        (S_AXI_ARESETN),
    .S_AXI_AWADDR         (S_AXI_AWADDR),
    .S_AXI_AWVALID        (S_AXI_AWVALID),
    .S_AXI_AWREADY        (S_AXI_AWREADY),
    .S_AXI_WDATA          (S_AXI_WDATA),
    .S_AXI_WSTRB          (S_AXI_WSTRB),
    .S_AXI_WVALID         (S_AXI_WVALID),
    .S_AXI_WREADY         (S_AXI_WREADY),
    .S_AXI_BRESP          (S_AXI_BRESP),
    .S_AXI_BVALID         (S_AXI_BVALID),
    .S_AXI_BREADY         (S_AXI_BREADY),
    .S_AXI_ARADDR         (S_AXI_ARADDR),
    .S_AXI_ARVALID        (S_AXI_ARVALID),
    .S_AXI_ARREADY        (S_AXI_ARREADY),
    .S_AXI_RDATA          (S_AXI_RDATA),
    .S_AXI_RRESP          (S_AXI_RRESP),
    .S_AXI_RVALID         (S_AXI_RVALID),
    .S_AXI_RREADY         (S_AXI_RREADY),
    .i_cu_status          (stat_in[0]),
    .i_exmu_status        (stat_in[1]),
    .i_memmu_status       (stat_in[2]),
    .i_monu_status        (stat_in[3]),
    .i_siu_status         (stat_in[4]),
    .i_ext_status         (stat_in[5]),
    .i_cu_ext_ready       (flag_in[0]),
    .i_cu_pc_ready        (flag_in[1]),
    .i_cu_processing_done (flag_in[2]),
    .i_dp                 (dp_in),
    .o_cu_param           (cu_param),
    .o_memmu_param        (memmu_param),
    .o_exmu_param         (exmu_param),
    .o_monu_param         (monu_param),
    .o_siu_param          (siu_param),
    .o_cu_pc_ready        (pc_ready),
    .o_cu_processing_done (proc_done),
    .o_cu_frame_done      (frame_done),
    .o_point_cloud_size   (pc_size),
    .o_user               (user_out),
    .o_status             (alive)
  );

  bind monu_top monu_props u_props (
    .i_clk     (S_AXI_ACLK),
    .i_rst_n   (S_AXI_ARESETN),
    .i_awvalid (S_AXI_AWVALID),
    .i_wvalid  (S_AXI_WVALID),
    .i_awready (S_AXI_AWREADY),
    .i_wready  (S_AXI_WREADY),
    .i_bvalid  (S_AXI_BVALID),
    .i_bready  (S_AXI_BREADY),
    .i_arready (S_AXI_ARREADY),
    .i_rvalid  (S_AXI_RVALID),
    .i_rready  (S_AXI_RREADY),
    .i_rdata   (S_AXI_RDATA)
  );

  // --------------------
  // Reference model
  function automatic word_t byte_merge(input word_t old, input word_t data, input strb_t strb);
    word_t res;
    res = old;
    for (int b = 0; b < `MONU_DATA_W / 8; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // Only the control bank takes writes
  function automatic void apply_write(input reg_idx_t idx, input word_t data, input strb_t strb);
    int i;
    i = int'(idx) - CTRL_BASE;
    if (i >= 0 && i < `MONU_CTRL_N) begin
      ctrl_model[i] = byte_merge(ctrl_model[i], data, strb);
    end
  endfunction

  function automatic word_t expected_word(input reg_idx_t idx);
    int i;
    i = int'(idx);
    if (i < `MONU_STAT_RSVD) begin
      return stat_in[i];
    end
    if (i == `MONU_STAT_RSVD) begin
      return '0;
    end
    if (i < `MONU_STAT_DP_BASE) begin
      return word_t'(flag_in[i - `MONU_STAT_FLAG]);
    end
    if (i < `MONU_STAT_N) begin
      return dp_in[i - `MONU_STAT_DP_BASE];
    end
    if (i >= CTRL_BASE && i < CTRL_BASE + `MONU_CTRL_N) begin
      return ctrl_model[i - CTRL_BASE];
    end
    return '0;
  endfunction

  task automatic check_value(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      err_value++;
      $display("ERR %0t: %s is %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  // --------------------
  // Compare process, outputs every cycle and each finished read
  always @(posedge S_AXI_ACLK) begin : compare
    if (rd_seen != rd_count) begin
      rd_seen = rd_count;
      check_value($sformatf("read of index 0x%02h", rd_idx_last), rd_got_last,
                  expected_word(rd_idx_last));
    end
    if (regs_cleared) begin
      check_value("o_cu_param", cu_param, ctrl_model[`MONU_CTRL_CU_PARAM]);
      check_value("o_memmu_param", memmu_param, ctrl_model[`MONU_CTRL_MEMMU_PARAM]);
      check_value("o_exmu_param", exmu_param, ctrl_model[`MONU_CTRL_EXMU_PARAM]);
      check_value("o_monu_param", monu_param, ctrl_model[`MONU_CTRL_MONU_PARAM]);
      check_value("o_siu_param", siu_param, ctrl_model[`MONU_CTRL_SIU_PARAM]);
      check_value("o_point_cloud_size", pc_size, ctrl_model[`MONU_CTRL_PC_SIZE]);
      // Flags follow a nonzero word
      check_value("o_cu_pc_ready", word_t'(pc_ready),
                  word_t'(|ctrl_model[`MONU_CTRL_PC_READY]));
      check_value("o_cu_processing_done", word_t'(proc_done),
                  word_t'(|ctrl_model[`MONU_CTRL_PROC_DONE]));
      check_value("o_cu_frame_done", word_t'(frame_done),
                  word_t'(|ctrl_model[`MONU_CTRL_FRAME_DONE]));
      for (int k = 0; k < `MONU_USER_N; k++) begin
        check_value($sformatf("o_user[%0d]", k), user_out[k],
                    ctrl_model[`MONU_CTRL_USER0 + k]);
      end
    end
    if (!S_AXI_ARESETN) begin
      regs_cleared = 1'b1;
    end
  end

  always @(posedge S_AXI_ACLK) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  // --------------------
  // AXI4-Lite master tasks, all driven on the falling edge
  task automatic start_write(input reg_idx_t idx, input word_t data, input strb_t strb);
    S_AXI_AWADDR  = 32'(idx) << `MONU_ADDR_LSB;
    S_AXI_WDATA   = data;
    S_AXI_WSTRB   = strb;
    S_AXI_AWVALID = 1'b1;
    S_AXI_WVALID  = 1'b1;
  endtask

  task automatic accept_write();
    @(negedge S_AXI_ACLK);
    while (!S_AXI_AWREADY) @(negedge S_AXI_ACLK);
    if (!S_AXI_WREADY) begin
      err_proto++;
      $display("WREADY was low in the cycle where AWREADY was high");
    end
    @(negedge S_AXI_ACLK);
    S_AXI_AWVALID = 1'b0;
    S_AXI_WVALID  = 1'b0;
    apply_write(S_AXI_AWADDR[`MONU_ADDR_LSB +: `MONU_IDX_W], S_AXI_WDATA, S_AXI_WSTRB);
    if (!S_AXI_BVALID) begin
      err_proto++;
      $display("No write response in the cycle after the write handshake");
    end
    if (S_AXI_BRESP !== 2'b00) begin
      err_bus++;
      $display("ERR %0t: BRESP is %0b, expected OKAY", $time, S_AXI_BRESP);
    end
  endtask

  // BREADY stays low for hold cycles before the response is taken
  task automatic take_response(input int hold);
    repeat (hold) begin
      @(negedge S_AXI_ACLK);
      if (!S_AXI_BVALID) begin
        err_proto++;
        $display("BVALID dropped while BREADY was low");
      end
      if (S_AXI_AWREADY) begin
        err_proto++;
        $display("A new write was accepted before the response was taken");
      end
    end
    S_AXI_BREADY = 1'b1;
    @(negedge S_AXI_ACLK);
    S_AXI_BREADY = 1'b0;
  endtask

  task automatic write_word(input reg_idx_t idx, input word_t data, input strb_t strb);
    start_write(idx, data, strb);
    accept_write();
    take_response(0);
  endtask

  task automatic read_word(input reg_idx_t idx, input int hold);
    word_t got;
    S_AXI_ARADDR  = 32'(idx) << `MONU_ADDR_LSB;
    S_AXI_ARVALID = 1'b1;
    @(negedge S_AXI_ACLK);
    while (!S_AXI_ARREADY) @(negedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    S_AXI_ARVALID = 1'b0;
    if (!S_AXI_RVALID) begin
      err_proto++;
      $display("No read data in the cycle after the read address handshake");
    end
    if (S_AXI_RRESP !== 2'b00) begin
      err_bus++;
      $display("ERR %0t: RRESP is %0b, expected OKAY", $time, S_AXI_RRESP);
    end
    got = S_AXI_RDATA;
    repeat (hold) begin
      @(negedge S_AXI_ACLK);
      if (!S_AXI_RVALID || S_AXI_RDATA !== got) begin
        err_proto++;
        $display("Read data changed while RREADY was low");
      end
    end
    S_AXI_RREADY = 1'b1;
    @(negedge S_AXI_ACLK);
    S_AXI_RREADY = 1'b0;
    rd_idx_last = idx;
    rd_got_last = got;
    rd_count++;
  endtask

  task automatic check_idle(input logic exp_alive);
    if (S_AXI_BVALID || S_AXI_RVALID) begin
      err_proto++;
      $display("A response is pending without any transfer");
    end
    if (alive !== exp_alive) begin
      err_bus++;
      $display("ERR %0t: o_status is %0b, expected %0b", $time, alive, exp_alive);
    end
  endtask

  // --------------------
  // Stimulus
  initial begin
    word_t    data;
    reg_idx_t idx;
    seed          = 32'h64aaf83e;
    S_AXI_AWADDR  = '0;
    S_AXI_AWVALID = 1'b0;
    S_AXI_WDATA   = '0;
    S_AXI_WSTRB   = '0;
    S_AXI_WVALID  = 1'b0;
    S_AXI_BREADY  = 1'b0;
    S_AXI_ARADDR  = '0;
    S_AXI_ARVALID = 1'b0;
    S_AXI_RREADY  = 1'b0;
    flag_in       = '0;
    dp_in         = '0;
    foreach (stat_in[k]) begin
      stat_in[k] = '0;
    end
    foreach (ctrl_model[k]) begin
      ctrl_model[k] = '0;
    end

    // Reset state, then alive one cycle after release
    repeat (2) @(negedge S_AXI_ACLK);
    check_idle(1'b0);
    while (!S_AXI_ARESETN) @(negedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    check_idle(1'b1);

    // Full strobes, every third word zero so the flags see both levels
    for (int k = 0; k < `MONU_CTRL_N; k++) begin
      data = (k % 3 == 0) ? '0 : word_t'($random(seed));
      write_word(reg_idx_t'(CTRL_BASE + k), data, 4'hF);
      read_word(reg_idx_t'(CTRL_BASE + k), 0);
    end

    // Random words and strobes
    for (int n = 0; n < 16; n++) begin
      idx  = reg_idx_t'(CTRL_BASE + ({$random(seed)} % `MONU_CTRL_N));
      data = $random(seed);
      write_word(idx, data, strb_t'($random(seed)));
      read_word(idx, 0);
    end

    // Status bank held stable while read
    for (int k = 0; k < 6; k++) begin
      stat_in[k] = $random(seed);
    end
    for (int k = 0; k < `MONU_DP_N; k++) begin
      dp_in[k] = $random(seed);
    end
    flag_in = 3'b101;
    @(negedge S_AXI_ACLK);
    for (int k = 0; k < `MONU_STAT_N; k++) begin
      read_word(reg_idx_t'(k), 0);
    end

    // Status and unmapped writes are dropped
    foreach (NO_WRITE_IDX[k]) begin
      write_word(NO_WRITE_IDX[k], 32'hFFFF_FFFF, 4'hF);
      read_word(NO_WRITE_IDX[k], 0);
    end

    // Back-pressure on both response channels
    start_write(reg_idx_t'(CTRL_BASE + `MONU_CTRL_PC_SIZE), word_t'($random(seed)), 4'hF);
    accept_write();
    start_write(reg_idx_t'(CTRL_BASE + `MONU_CTRL_USER0), word_t'($random(seed)), 4'hF);
    take_response(6);
    accept_write();
    take_response(0);
    read_word(reg_idx_t'(CTRL_BASE + `MONU_CTRL_PC_SIZE), 5);

    repeat (2) @(negedge S_AXI_ACLK);
    $display("Checks %0d, value errors %0d, bus errors %0d, protocol errors %0d",
             checks, err_value, err_bus, err_proto);
    if (err_value + err_bus + err_proto == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
